/* include/serial_pc_defines.svh */
`ifndef SERIAL_PC_DEFINES_SVH
`define SERIAL_PC_DEFINES_SVH

// ***********************************************************************
// core wide constants
// ***********************************************************************

// word width, one bit per clock in a pass
`define SPC_XLEN 32

// first fetch address out of reset
`define SPC_RESET_PC 32'h0000_0008

`endif

/* src/serial_pc_pkg.sv */
`include "serial_pc_defines.svh"

package serial_pc_pkg;

   // ********************************************************************
   // words and counters
   // ********************************************************************

   // pc, offset, trap vector and rd value
   typedef logic [`SPC_XLEN-1:0] pc_t;

   // which four-bit group of the word is on the line
   typedef logic [2:0] bitcnt_t;

   // one-hot bit position inside a group
   typedef logic [3:0] phase_t;

   // ********************************************************************
   // step results
   // ********************************************************************

   // where the next pc comes from
   typedef enum logic [1:0] {
      SRC_SEQ  = 2'd0,   // pc + 4
      SRC_JUMP = 2'd1,   // pc relative or absolute target
      SRC_TRAP = 2'd2    // trap vector
   } pc_src_e;

endpackage

/* src/serial_adder.sv */
`timescale 1ns/1ps

module serial_adder (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry;
   logic carry_nxt;

   // full adder, carry held between bits
   assign o_q       = i_a ^ i_b ^ carry;
   assign carry_nxt = (i_a & i_b) | (carry & (i_a ^ i_b));

   always_ff @(posedge clk) begin
      if (i_rst || i_clr) begin
         carry <= 1'b0;   // fresh word on the next pass
      end else begin
         carry <= carry_nxt;
      end
   end

endmodule

/* src/pc_shift_reg.sv */
`timescale 1ns/1ps
`include "serial_pc_defines.svh"

module pc_shift_reg (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_en,
   input  logic                 i_d,
   output logic                 o_q,
   output logic [`SPC_XLEN-1:1] o_par
);

   logic [`SPC_XLEN-1:0] data;

   // ********************************************************************
   // circular shifter, new bits enter at the top
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (i_rst) begin
         data <= `SPC_RESET_PC;
      end else if (i_en) begin
         data <= {i_d, data[`SPC_XLEN-1:1]};
      end
   end

   // lsb is the bit on the line during a pass
   assign o_q = data[0];

   // full word readable while idle
   assign o_par = data[`SPC_XLEN-1:1];

endmodule

/* src/pc_ctrl.sv */
`timescale 1ns/1ps
`include "serial_pc_defines.svh"

module pc_ctrl (
   input  logic                   clk,
   input  logic                   i_rst,
   // step state
   input  logic                   i_pc_en,
   input  serial_pc_pkg::bitcnt_t i_cnt,
   input  serial_pc_pkg::phase_t  i_cnt_r,
   input  logic                   i_cnt_done,
   // control
   input  logic                   i_jump,
   input  logic                   i_jal_or_jalr,
   input  logic                   i_utype,
   input  logic                   i_pc_rel,
   input  logic                   i_trap,
   // serial data
   input  logic                   i_imm,
   input  logic                   i_buf,
   input  logic                   i_csr_pc,
   output logic                   o_rd,
   output logic                   o_bad_pc,
   // instruction bus
   output serial_pc_pkg::pc_t     o_ibus_adr,
   output logic                   o_ibus_cyc,
   input  logic                   i_ibus_ack
);

   import serial_pc_pkg::*;

   logic                 fetch_pend;
   logic                 pc_bit;
   logic [`SPC_XLEN-1:1] pc_upper;
   logic                 plus_4;
   logic                 pc_plus_4;
   logic                 offset_a;
   logic                 offset_b;
   logic                 pc_plus_offset;
   logic                 pc_plus_offset_aligned;
   logic                 new_pc;
   pc_src_e              pc_src;

   // ********************************************************************
   // serial adders
   // ********************************************************************

   // single one injected at bit 2
   assign plus_4 = i_cnt_r[2] & (i_cnt == bitcnt_t'(0));

   serial_adder u_add_plus_4 (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc_bit),
      .i_b   (plus_4),
      .i_clr (i_cnt_done),
      .o_q   (pc_plus_4)
   );

   assign offset_a = i_pc_rel & pc_bit;           // absolute target when pc_rel is low
   assign offset_b = i_utype ? i_imm : i_buf;

   serial_adder u_add_offset (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (offset_a),
      .i_b   (offset_b),
      .i_clr (!i_pc_en),
      .o_q   (pc_plus_offset)
   );

   // flag is still low on bit 0, which clears the lsb of the target
   assign pc_plus_offset_aligned = pc_plus_offset & fetch_pend;
   assign o_bad_pc               = pc_plus_offset_aligned;

   // ********************************************************************
   // next pc and rd
   // ********************************************************************

   always_comb begin
      if (i_trap) begin
         pc_src = SRC_TRAP;
      end else if (i_jump) begin
         pc_src = SRC_JUMP;
      end else begin
         pc_src = SRC_SEQ;
      end
   end

   always_comb begin
      case (pc_src)
         SRC_TRAP: new_pc = i_csr_pc & fetch_pend;
         SRC_JUMP: new_pc = pc_plus_offset_aligned;
         default:  new_pc = pc_plus_4;
      endcase
   end

   assign o_rd = (i_utype & pc_plus_offset) | (i_jal_or_jalr & pc_plus_4);

   pc_shift_reg u_pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc_bit),
      .o_par (pc_upper)
   );

   // ********************************************************************
   // fetch request
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (i_rst) begin
         fetch_pend <= 1'b1;              // fetch the reset pc first
      end else if (i_pc_en) begin
         fetch_pend <= 1'b1;
      end else if (o_ibus_cyc && i_ibus_ack) begin
         fetch_pend <= 1'b0;
      end
   end

   assign o_ibus_cyc = fetch_pend & !i_pc_en;
   assign o_ibus_adr = {pc_upper, pc_bit};

endmodule

/* src/step_sequencer.sv */
`timescale 1ns/1ps

module step_sequencer (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_start,
   output logic                   o_load,
   output logic                   o_pc_en,
   output logic                   o_cnt_done,
   output logic                   o_ready,
   output serial_pc_pkg::bitcnt_t o_cnt,
   output serial_pc_pkg::phase_t  o_cnt_r
);

   import serial_pc_pkg::*;

   localparam logic [4:0] LAST_POS = 5'd31;

   logic       running;
   logic [4:0] pos;       // bit index within the pass
   phase_t     ring;

   // ********************************************************************
   // pass window
   // ********************************************************************

   assign o_ready    = !running;
   assign o_load     = i_start & o_ready;   // starts while busy are dropped
   assign o_cnt_done = running & (pos == LAST_POS);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         running <= 1'b0;
      end else if (o_load) begin
         running <= 1'b1;
      end else if (o_cnt_done) begin
         running <= 1'b0;
      end
   end

   // ********************************************************************
   // bit position and phase ring
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pos  <= '0;
         ring <= 4'b0001;
      end else if (running) begin
         pos  <= pos + 5'd1;                  // wraps to 0 after the last bit
         ring <= {ring[2:0], ring[3]};
      end
   end

   assign o_pc_en = running;
   assign o_cnt   = pos[4:2];
   assign o_cnt_r = ring;

endmodule

/* src/word_serializer.sv */
`timescale 1ns/1ps

module word_serializer (
   input  logic               clk,
   input  logic               i_load,
   input  logic               i_en,
   input  serial_pc_pkg::pc_t i_word,
   output logic               o_bit
);

   import serial_pc_pkg::*;

   pc_t shreg;

   // ********************************************************************
   // parallel in, serial out
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (i_load) begin
         shreg <= i_word;
      end else if (i_en) begin
         shreg <= shreg >> 1;     // next bit moves down to the lsb
      end
   end

   // lsb first
   assign o_bit = shreg[0];

endmodule

/* src/rd_collector.sv */
`timescale 1ns/1ps

module rd_collector (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_en,
   input  logic               i_bit,
   input  logic               i_last,
   output serial_pc_pkg::pc_t o_word,
   output logic               o_valid
);

   import serial_pc_pkg::*;

   pc_t word;
   logic valid;

   // lsb arrives first, so after a full pass it sits at bit 0
   always_ff @(posedge clk) begin
      if (i_en) begin
         word <= {i_bit, word[$bits(pc_t)-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid <= 1'b0;
      end else begin
         valid <= i_en & i_last;   // one cycle after the final bit
      end
   end

   assign o_word  = word;
   assign o_valid = valid;

endmodule

/* src/serial_pc_top.sv */
`timescale 1ns/1ps

module serial_pc_top (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_start,
   // step control, held through the pass
   input  logic               i_jump,
   input  logic               i_jal_or_jalr,
   input  logic               i_utype,
   input  logic               i_pc_rel,
   input  logic               i_trap,
   input  serial_pc_pkg::pc_t i_offset,
   input  serial_pc_pkg::pc_t i_trap_vec,
   // instruction bus
   input  logic               i_ibus_ack,
   output logic               o_ready,
   output serial_pc_pkg::pc_t o_ibus_adr,
   output logic               o_ibus_cyc,
   // rd result
   output serial_pc_pkg::pc_t o_rd_value,
   output logic               o_rd_valid
);

   import serial_pc_pkg::*;

   logic    load;
   logic    pc_en;
   logic    cnt_done;
   bitcnt_t cnt;
   phase_t  cnt_r;
   logic    offset_bit;
   logic    trap_bit;
   logic    rd_bit;

   step_sequencer u_seq (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .o_load     (load),
      .o_pc_en    (pc_en),
      .o_cnt_done (cnt_done),
      .o_ready    (o_ready),
      .o_cnt      (cnt),
      .o_cnt_r    (cnt_r)
   );

   word_serializer u_offset_ser (
      .clk    (clk),
      .i_load (load),
      .i_en   (pc_en),
      .i_word (i_offset),
      .o_bit  (offset_bit)
   );

   word_serializer u_trap_ser (
      .clk    (clk),
      .i_load (load),
      .i_en   (pc_en),
      .i_word (i_trap_vec),
      .o_bit  (trap_bit)
   );

   // misaligned target bit has no consumer here
   pc_ctrl u_ctrl (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_pc_en       (pc_en),
      .i_cnt         (cnt),
      .i_cnt_r       (cnt_r),
      .i_cnt_done    (cnt_done),
      .i_jump        (i_jump),
      .i_jal_or_jalr (i_jal_or_jalr),
      .i_utype       (i_utype),
      .i_pc_rel      (i_pc_rel),
      .i_trap        (i_trap),
      .i_imm         (offset_bit),
      .i_buf         (offset_bit),
      .i_csr_pc      (trap_bit),
      .o_rd          (rd_bit),
      .o_bad_pc      (),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc),
      .i_ibus_ack    (i_ibus_ack)
   );

   rd_collector u_rd (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_en    (pc_en),
      .i_bit   (rd_bit),
      .i_last  (cnt_done),
      .o_word  (o_rd_value),
      .o_valid (o_rd_valid)
   );

endmodule

/* bench/tb_pc_properties.sv */
`timescale 1ns/1ps

module tb_pc_properties (
   input logic               clk,
   input logic               i_rst,
   input logic               i_start,
   input logic               i_ibus_ack,
   input logic               o_ready,
   input serial_pc_pkg::pc_t o_ibus_adr,
   input logic               o_ibus_cyc,
   input logic               o_rd_valid
);

   localparam int STEP_CYC = 33;   // start cycle to first idle cycle

   logic start_ok;
   int   n_fail = 0;

   assign start_ok = i_start & o_ready;

   // ********************************************************************
   // instruction fetch
   // ********************************************************************

   a_cyc_after_reset: assert property (@(posedge clk) $fell(i_rst) |-> o_ibus_cyc)
      else begin
         $error("no fetch request after reset");
         n_fail++;
      end

   // request and address hold until the ack
   a_adr_stable: assert property (@(posedge clk) disable iff (i_rst)
      (o_ibus_cyc && !i_ibus_ack) |=> (o_ibus_cyc && $stable(o_ibus_adr)))
      else begin
         $error("fetch request or address changed before ack");
         n_fail++;
      end

   // ********************************************************************
   // step timing
   // ********************************************************************

   a_rd_valid: assert property (@(posedge clk) disable iff (i_rst)
      o_rd_valid == $past(start_ok, STEP_CYC))
      else begin
         $error("rd valid not exactly %0d cycles after start", STEP_CYC);
         n_fail++;
      end

   a_cyc_rise: assert property (@(posedge clk) disable iff (i_rst)
      $past(start_ok, STEP_CYC) |-> $rose(o_ibus_cyc))
      else begin
         $error("fetch request did not rise %0d cycles after start", STEP_CYC);
         n_fail++;
      end

endmodule

bind serial_pc_top tb_pc_properties u_props (
   .clk        (clk),
   .i_rst      (i_rst),
   .i_start    (i_start),
   .i_ibus_ack (i_ibus_ack),
   .o_ready    (o_ready),
   .o_ibus_adr (o_ibus_adr),
   .o_ibus_cyc (o_ibus_cyc),
   .o_rd_valid (o_rd_valid)
);

/* bench/tb_serial_pc.sv */
`timescale 1ns/1ps
`include "serial_pc_defines.svh"

module tb_serial_pc;

   import serial_pc_pkg::*;

   localparam int N_STEPS  = 25;
   localparam int WDOG_CYC = N_STEPS * 50 + 200;

   logic clk;
   logic i_rst;
   logic i_start;
   logic i_jump;
   logic i_jal_or_jalr;
   logic i_utype;
   logic i_pc_rel;
   logic i_trap;
   pc_t  i_offset;
   pc_t  i_trap_vec;
   logic i_ibus_ack;
   logic o_ready;
   pc_t  o_ibus_adr;
   logic o_ibus_cyc;
   pc_t  o_rd_value;
   logic o_rd_valid;

   logic [31:0] lfsr = 32'h6187;
   pc_t         model_pc;
   pc_t         off;
   pc_t         vec;
   int          n_err;
   int          err_mark;
   int          n_pass;
   int          n_fail;

   serial_pc_top u_dut (.*);

   always #20 clk = ~clk;

   // ********************************************************************
   // random source and checks
   // ********************************************************************

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic draw_operands();
      off = rand_bits(32);
      vec = rand_bits(32);
   endtask

   function automatic int error_total();
      return n_err + u_dut.u_props.n_fail;
   endfunction

   task automatic check_word(input string name, input pc_t got, input pc_t exp);
      assert (got == exp) else begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         n_err++;
      end
   endtask

   task automatic expect_flag(input string name, input logic got, input logic exp);
      assert (got == exp) else begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         n_err++;
      end
   endtask

   task automatic report_test(input string name);
      if (error_total() == err_mark) begin
         n_pass++;
         $display("test %s: pass", name);
      end else begin
         n_fail++;
         $display("test %s: fail with %0d errors", name, error_total() - err_mark);
      end
      err_mark = error_total();
   endtask

   // ********************************************************************
   // bus and step drivers
   // ********************************************************************

   task automatic ack_fetch(input int unsigned delay);
      pc_t held;
      held = o_ibus_adr;
      for (int unsigned i = 0; i < delay; i++) begin
         @(posedge clk);
         #2;
         expect_flag("o_ibus_cyc", o_ibus_cyc, 1'b1);
         check_word("o_ibus_adr", o_ibus_adr, held);
      end
      i_ibus_ack = 1'b1;
      @(posedge clk);
      #2;
      i_ibus_ack = 1'b0;
      expect_flag("o_ibus_cyc", o_ibus_cyc, 1'b0);   // drops the cycle after ack
      expect_flag("o_ready", o_ready, 1'b1);
   endtask

   task automatic run_step(input logic jump, input logic jal, input logic utype,
                           input logic pc_rel, input logic trap, input pc_t offset,
                           input pc_t tvec, input int unsigned delay);
      pc_src_e src;
      pc_t     sum;
      pc_t     exp_pc;
      pc_t     exp_rd;
      src = trap ? SRC_TRAP : (jump ? SRC_JUMP : SRC_SEQ);
      sum = (pc_rel ? model_pc : pc_t'(0)) + offset;
      case (src)
         SRC_TRAP: exp_pc = {tvec[31:1], 1'b0};
         SRC_JUMP: exp_pc = {sum[31:1], 1'b0};
         default:  exp_pc = model_pc + 32'd4;
      endcase
      if (utype) begin
         exp_rd = sum;
      end else if (jal) begin
         exp_rd = model_pc + 32'd4;
      end else begin
         exp_rd = '0;
      end
      expect_flag("o_ready", o_ready, 1'b1);
      i_jump        = jump;
      i_jal_or_jalr = jal;
      i_utype       = utype;
      i_pc_rel      = pc_rel;
      i_trap        = trap;
      i_offset      = offset;
      i_trap_vec    = tvec;
      i_start       = 1'b1;
      @(posedge clk);
      #2;
      i_start = 1'b0;
      expect_flag("o_ibus_cyc", o_ibus_cyc, 1'b0);   // pass running
      while (!o_rd_valid) begin
         @(posedge clk);
         #2;
      end
      check_word("o_rd_value", o_rd_value, exp_rd);
      expect_flag("o_ibus_cyc", o_ibus_cyc, 1'b1);
      check_word("o_ibus_adr", o_ibus_adr, exp_pc);
      model_pc = exp_pc;
      ack_fetch(delay);
   endtask

   // ********************************************************************
   // tests
   // ********************************************************************

   initial begin
      logic [1:0]  kind;
      int unsigned dly;
      clk           = 1'b0;
      i_rst         = 1'b1;
      i_start       = 1'b0;
      i_jump        = 1'b0;
      i_jal_or_jalr = 1'b0;
      i_utype       = 1'b0;
      i_pc_rel      = 1'b0;
      i_trap        = 1'b0;
      i_offset      = '0;
      i_trap_vec    = '0;
      i_ibus_ack    = 1'b0;
      model_pc      = `SPC_RESET_PC;
      n_err         = 0;
      err_mark      = 0;
      n_pass        = 0;
      n_fail        = 0;
      repeat (5) @(posedge clk);
      #2;
      i_rst = 1'b0;

      expect_flag("o_ibus_cyc", o_ibus_cyc, 1'b1);
      check_word("o_ibus_adr", o_ibus_adr, `SPC_RESET_PC);
      expect_flag("o_rd_valid", o_rd_valid, 1'b0);
      ack_fetch(0);
      report_test("reset fetch");

      repeat (4) begin
         draw_operands();
         run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, off, vec, 0);
      end
      report_test("sequential steps");

      repeat (3) begin
         draw_operands();
         run_step(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, off, vec, 0);   // jal
      end
      repeat (2) begin
         draw_operands();
         run_step(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, off, vec, 0);   // absolute target
      end
      report_test("jumps");

      repeat (2) begin
         draw_operands();
         run_step(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, off, vec, 0);
         draw_operands();
         run_step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, off, vec, 0);
      end
      report_test("utype steps");

      draw_operands();
      run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, off, vec, 0);
      draw_operands();
      run_step(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, off, vec, 0);
      draw_operands();
      run_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, off, vec, 0);
      report_test("traps");

      for (int i = 0; i < 8; i++) begin
         draw_operands();
         kind = 2'(rand_bits(2));
         dly  = rand_bits(3);
         case (kind)
            2'd0:    run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, off, vec, dly);
            2'd1:    run_step(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, off, vec, dly);
            2'd2:    run_step(1'b0, 1'b0, 1'b1, off[0], 1'b0, off, vec, dly);
            default: run_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, off, vec, dly);
         endcase
      end
      report_test("random ack delays");

      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
      if (n_fail == 0 && error_total() == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      #(WDOG_CYC * 40);
      $display("watchdog expired, run did not finish within %0d clock periods", WDOG_CYC);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+include
src/serial_pc_pkg.sv
src/serial_adder.sv
src/pc_shift_reg.sv
src/pc_ctrl.sv
src/step_sequencer.sv
src/word_serializer.sv
src/rd_collector.sv
src/serial_pc_top.sv
bench/tb_pc_properties.sv
bench/tb_serial_pc.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_serial_pc -f filelist.f -Mdir obj_dir
	./obj_dir/Vtb_serial_pc +verilator+error+limit+1000 | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
